// File: source/conv_pe_defines.svh
`ifndef CONV_PE_DEFINES_SVH
`define CONV_PE_DEFINES_SVH

// tile geometry
`define CH_NUM            4
`define ACT_PER_ADDR      4
`define WEIGHT_PER_ADDR   9

// data widths
`define BW_PER_ACT        8
`define BW_PER_PARAM      4
`define ACT_WORD_W        128
`define WEIGHT_WORD_W     36
`define ACC_W             16

// output clamp ceiling
`define ACT_MAX           127

// per-layer requantization
`define CONV1_SHIFT       7
`define CONV2_SHIFT       5
`define CONV1_BIAS_SHIFT  7
`define CONV2_BIAS_SHIFT  3

`endif

// File: source/conv_pe_pkg.sv
`default_nettype none

`include "conv_pe_defines.svh"

package conv_pe_pkg;

    // one activation word, read either as a flat list or as channel x pixel
    // pixel order is top-left, top-right, bottom-left, bottom-right
    typedef union packed {
        logic [0:`CH_NUM*`ACT_PER_ADDR-1][`BW_PER_ACT-1:0] flat;
        logic [0:`CH_NUM-1][0:`ACT_PER_ADDR-1][`BW_PER_ACT-1:0] chan;
    } act_word_u;

endpackage

`default_nettype wire

// File: source/acc_if.sv
`default_nettype none

`include "conv_pe_defines.svh"

interface acc_if;

    // raw sums for the four outputs of one window
    logic signed [`ACC_W-1:0] acc0;
    logic signed [`ACC_W-1:0] acc1;
    logic signed [`ACC_W-1:0] acc2;
    logic signed [`ACC_W-1:0] acc3;
    logic                     valid;
    // 0 = layer one, 1 = layer two
    logic                     layer;

    modport mac (
        output acc0, acc1, acc2, acc3,
        output valid, layer
    );

    modport requant (
        input acc0, acc1, acc2, acc3,
        input valid, layer
    );

endinterface

`default_nettype wire

// File: source/param_buffer.sv
`default_nettype none

`include "conv_pe_defines.svh"

module param_buffer (
    input  wire logic                                       clk,
    input  wire logic                                       rst_n,
    input  wire logic                                       busy_window,
    input  wire logic                                       weight_load,
    input  wire logic [`WEIGHT_WORD_W-1:0]                  weight_word,
    input  wire logic                                       bias_load,
    input  wire logic [`BW_PER_PARAM-1:0]                   bias_in,
    output logic      [`CH_NUM*`WEIGHT_WORD_W-1:0]          weights,
    output logic signed [`BW_PER_PARAM-1:0]                 bias_q
);

    // channel 0 kernel sits in the top 36 bits
    logic [`CH_NUM*`WEIGHT_WORD_W-1:0] kernel_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kernel_q <= '0;
        end else if (weight_load) begin
            // older kernels move toward channel 0, new one enters at channel 3
            kernel_q <= {kernel_q[(`CH_NUM-1)*`WEIGHT_WORD_W-1:0], weight_word};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bias_q <= '0;
        end else if (bias_load) begin
            bias_q <= bias_in;
        end
    end

    assign weights = kernel_q;

    // weights are read one edge after capture, bias two edges after that,
    // so a window is exposed to loads on its capture edge and the next two
    load_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        busy_window |-> !(weight_load || bias_load) [*3]
    ) else $error("parameter load while a window is in flight");

endmodule

`default_nettype wire

// File: source/conv_mac.sv
`default_nettype none

`include "conv_pe_defines.svh"

module conv_mac
    import conv_pe_pkg::*;
(
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               window_valid,
    input  wire logic                               layer,
    input  wire logic [`ACT_WORD_W-1:0]             win0,
    input  wire logic [`ACT_WORD_W-1:0]             win1,
    input  wire logic [`ACT_WORD_W-1:0]             win2,
    input  wire logic [`ACT_WORD_W-1:0]             win3,
    input  wire logic [`CH_NUM*`WEIGHT_WORD_W-1:0]  weights,
    acc_if.mac                                      acc
);

    localparam int NUM_W  = `CH_NUM * `WEIGHT_PER_ADDR;
    localparam int NUM_PS = `CH_NUM * 3;
    localparam int PS_W   = `BW_PER_ACT + `BW_PER_PARAM + 2;

    act_word_u                    win_q [4];
    logic                         valid_q0;
    logic                         layer_q0;
    logic signed [`BW_PER_ACT-1:0]   tap [4][`CH_NUM][`WEIGHT_PER_ADDR];
    logic signed [`BW_PER_PARAM-1:0] wgt [NUM_W];
    logic signed [PS_W-1:0]       psum_d [4][NUM_PS];
    logic signed [PS_W-1:0]       psum_q [4][NUM_PS];
    logic                         valid_q1;
    logic                         layer_q1;
    logic signed [`ACC_W-1:0]     tree_d [4];

    // capture edge, words held for one cycle of gathering
    always_ff @(posedge clk) begin
        win_q[0].flat <= win0;
        win_q[1].flat <= win1;
        win_q[2].flat <= win2;
        win_q[3].flat <= win3;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q0 <= 1'b0;
            layer_q0 <= 1'b0;
        end else begin
            valid_q0 <= window_valid;
            layer_q0 <= layer;
        end
    end

    // unpack kernels, nibble 0 of channel 0 is the msb
    always_comb begin
        for (int n = 0; n < NUM_W; n++) begin
            wgt[n] = weights[(NUM_W-1-n)*`BW_PER_PARAM +: `BW_PER_PARAM];
        end
    end

    // 4x4 tile per channel: word picks the 2x2 quadrant, pixel the spot inside
    always_comb begin
        int r;
        int c;
        for (int k = 0; k < 4; k++) begin
            for (int chn = 0; chn < `CH_NUM; chn++) begin
                for (int p = 0; p < `WEIGHT_PER_ADDR; p++) begin
                    r = k / 2 + p / 3;
                    c = k % 2 + p % 3;
                    tap[k][chn][p] = win_q[(r/2)*2 + c/2].chan[chn][(r%2)*2 + c%2];
                end
            end
        end
    end

    // one partial sum per kernel row and channel
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            for (int chn = 0; chn < `CH_NUM; chn++) begin
                for (int row = 0; row < 3; row++) begin
                    psum_d[k][chn*3+row] = '0;
                    for (int j = 0; j < 3; j++) begin
                        psum_d[k][chn*3+row] = psum_d[k][chn*3+row]
                            + tap[k][chn][row*3+j] * wgt[chn*`WEIGHT_PER_ADDR + row*3 + j];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        psum_q <= psum_d;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q1 <= 1'b0;
            layer_q1 <= 1'b0;
        end else begin
            valid_q1 <= valid_q0;
            layer_q1 <= layer_q0;
        end
    end

    // 12-term tree, wraps at accumulator width
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            tree_d[k] = '0;
            for (int t = 0; t < NUM_PS; t++) begin
                tree_d[k] = tree_d[k] + psum_q[k][t];
            end
        end
    end

    always_ff @(posedge clk) begin
        acc.acc0 <= tree_d[0];
        acc.acc1 <= tree_d[1];
        acc.acc2 <= tree_d[2];
        acc.acc3 <= tree_d[3];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc.valid <= 1'b0;
            acc.layer <= 1'b0;
        end else begin
            acc.valid <= valid_q1;
            acc.layer <= layer_q1;
        end
    end

    // mode tag must be known, it selects the requant path three edges later
    layer_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        window_valid |-> !$isunknown(layer)
    ) else $error("layer unknown on window strobe");

endmodule

`default_nettype wire

// File: source/requant_relu.sv
`default_nettype none

`include "conv_pe_defines.svh"

module requant_relu (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    acc_if.requant                              acc,
    input  wire logic signed [`BW_PER_PARAM-1:0] bias_q,
    output logic                                out_valid,
    output logic [`BW_PER_ACT-1:0]              res0,
    output logic [`BW_PER_ACT-1:0]              res1,
    output logic [`BW_PER_ACT-1:0]              res2,
    output logic [`BW_PER_ACT-1:0]              res3
);

    // half an output step for round-to-nearest
    localparam logic signed [`ACC_W-1:0] RND1 = 1 <<< (`CONV1_SHIFT - 1);
    localparam logic signed [`ACC_W-1:0] RND2 = 1 <<< (`CONV2_SHIFT - 1);

    logic signed [`ACC_W-1:0]      acc_v [4];
    logic signed [`ACC_W-1:0]      bias_ext;
    logic signed [`ACC_W-1:0]      bias_sh;
    logic signed [`ACC_W-1:0]      rnd;
    logic signed [`ACC_W-1:0]      pre [4];
    logic signed [`ACC_W-1:0]      scaled [4];
    logic        [`BW_PER_ACT-1:0] res_d [4];
    logic        [`BW_PER_ACT-1:0] res_q [4];

    assign acc_v[0] = acc.acc0;
    assign acc_v[1] = acc.acc1;
    assign acc_v[2] = acc.acc2;
    assign acc_v[3] = acc.acc3;

    assign bias_ext = {{(`ACC_W-`BW_PER_PARAM){bias_q[`BW_PER_PARAM-1]}}, bias_q};
    assign bias_sh  = acc.layer ? (bias_ext <<< `CONV2_BIAS_SHIFT)
                                : (bias_ext <<< `CONV1_BIAS_SHIFT);
    assign rnd      = acc.layer ? RND2 : RND1;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            pre[i]    = acc_v[i] + bias_sh + rnd;
            scaled[i] = acc.layer ? (pre[i] >>> `CONV2_SHIFT) : (pre[i] >>> `CONV1_SHIFT);
            // relu then saturate
            if (scaled[i] < 0) begin
                res_d[i] = '0;
            end else if (scaled[i] >= `ACT_MAX) begin
                res_d[i] = `BW_PER_ACT'(`ACT_MAX);
            end else begin
                res_d[i] = scaled[i][`BW_PER_ACT-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            res_q     <= '{default: '0};
        end else begin
            out_valid <= acc.valid;
            if (acc.valid) begin
                res_q <= res_d;
            end
        end
    end

    assign res0 = res_q[0];
    assign res1 = res_q[1];
    assign res2 = res_q[2];
    assign res3 = res_q[3];

    res_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (res_q[0] <= `ACT_MAX) && (res_q[1] <= `ACT_MAX) &&
        (res_q[2] <= `ACT_MAX) && (res_q[3] <= `ACT_MAX)
    ) else $error("result above clamp ceiling");

endmodule

`default_nettype wire

// File: source/conv_pe_top.sv
`default_nettype none

`include "conv_pe_defines.svh"

module conv_pe_top (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         window_valid,
    input  wire logic                         layer,
    input  wire logic [`ACT_WORD_W-1:0]       win0,
    input  wire logic [`ACT_WORD_W-1:0]       win1,
    input  wire logic [`ACT_WORD_W-1:0]       win2,
    input  wire logic [`ACT_WORD_W-1:0]       win3,
    input  wire logic                         weight_load,
    input  wire logic [`WEIGHT_WORD_W-1:0]    weight_word,
    input  wire logic                         bias_load,
    input  wire logic [`BW_PER_PARAM-1:0]     bias,
    output logic                              out_valid,
    output logic [`BW_PER_ACT-1:0]            res0,
    output logic [`BW_PER_ACT-1:0]            res1,
    output logic [`BW_PER_ACT-1:0]            res2,
    output logic [`BW_PER_ACT-1:0]            res3
);

    logic [`CH_NUM*`WEIGHT_WORD_W-1:0] weights;
    logic signed [`BW_PER_PARAM-1:0]   bias_q;

    acc_if u_acc ();

    param_buffer u_param_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .busy_window (window_valid),
        .weight_load (weight_load),
        .weight_word (weight_word),
        .bias_load   (bias_load),
        .bias_in     (bias),
        .weights     (weights),
        .bias_q      (bias_q)
    );

    conv_mac u_conv_mac (
        .clk          (clk),
        .rst_n        (rst_n),
        .window_valid (window_valid),
        .layer        (layer),
        .win0         (win0),
        .win1         (win1),
        .win2         (win2),
        .win3         (win3),
        .weights      (weights),
        .acc          (u_acc.mac)
    );

    requant_relu u_requant_relu (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc       (u_acc.requant),
        .bias_q    (bias_q),
        .out_valid (out_valid),
        .res0      (res0),
        .res1      (res1),
        .res2      (res2),
        .res3      (res3)
    );

endmodule

`default_nettype wire

// File: tb/conv_pe_checker.sv
`default_nettype none

`include "conv_pe_defines.svh"

module conv_pe_checker (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          window_valid,
    input  wire logic                          layer,
    input  wire logic [`ACT_WORD_W-1:0]        win0,
    input  wire logic [`ACT_WORD_W-1:0]        win1,
    input  wire logic [`ACT_WORD_W-1:0]        win2,
    input  wire logic [`ACT_WORD_W-1:0]        win3,
    input  wire logic                          weight_load,
    input  wire logic [`WEIGHT_WORD_W-1:0]     weight_word,
    input  wire logic                          bias_load,
    input  wire logic [`BW_PER_PARAM-1:0]      bias,
    input  wire logic                          out_valid,
    input  wire logic [`BW_PER_ACT-1:0]        res0,
    input  wire logic [`BW_PER_ACT-1:0]        res1,
    input  wire logic [`BW_PER_ACT-1:0]        res2,
    input  wire logic [`BW_PER_ACT-1:0]        res3,
    output int                                 value_errors,
    output int                                 other_errors,
    output int                                 compared,
    output int                                 pending
);

    localparam int TILE_W  = 4 * `ACT_WORD_W;
    // window sampled on edge k, result seen here on edge k+4
    localparam int LATENCY = 4;

    // model copy of the parameters from the snooped loads
    logic signed [`BW_PER_PARAM-1:0] kern [`CH_NUM][`WEIGHT_PER_ADDR];
    logic signed [`BW_PER_PARAM-1:0] bias_m;
    logic        [`BW_PER_ACT-1:0]   exp_q [$];
    int                              cap_q [$];
    int                              cycle;

    function automatic logic [`BW_PER_ACT-1:0] expected_pixel(
        input logic [TILE_W-1:0] tile,
        input int                k,
        input logic              lay
    );
        logic signed [`ACC_W-1:0]      sum;
        logic signed [`ACC_W-1:0]      b16;
        logic signed [`ACC_W-1:0]      v;
        logic signed [`BW_PER_ACT-1:0] a;
        int row;
        int col;
        int word;
        int pix;
        int bsh;
        int osh;
        sum = '0;
        for (int ch = 0; ch < `CH_NUM; ch++) begin
            for (int p = 0; p < `WEIGHT_PER_ADDR; p++) begin
                // window corner at tile row k/2, column k%2
                row  = k / 2 + p / 3;
                col  = k % 2 + p % 3;
                word = (row < 2 ? 0 : 2) + (col < 2 ? 0 : 1);
                pix  = (row % 2) * 2 + col % 2;
                a    = tile[TILE_W - 1 - word * `ACT_WORD_W
                            - (ch * `ACT_PER_ADDR + pix) * `BW_PER_ACT -: `BW_PER_ACT];
                sum  = sum + a * kern[ch][p];
            end
        end
        bsh = lay ? `CONV2_BIAS_SHIFT : `CONV1_BIAS_SHIFT;
        osh = lay ? `CONV2_SHIFT : `CONV1_SHIFT;
        b16 = bias_m;
        v   = sum + (b16 <<< bsh) + (1 << osh) / 2;
        v   = v >>> osh;
        if (v < 0) begin
            return '0;
        end else if (v >= `ACT_MAX) begin
            return `BW_PER_ACT'(`ACT_MAX);
        end
        return v[`BW_PER_ACT-1:0];
    endfunction

    always @(posedge clk) begin
        logic [`BW_PER_ACT-1:0] got [4];
        logic [`BW_PER_ACT-1:0] want;
        int                     lat;
        if (!rst_n) begin
            exp_q.delete();
            cap_q.delete();
            cycle        = 0;
            bias_m       = '0;
            value_errors = 0;
            other_errors = 0;
            compared     = 0;
            for (int c = 0; c < `CH_NUM; c++) begin
                for (int p = 0; p < `WEIGHT_PER_ADDR; p++) begin
                    kern[c][p] = '0;
                end
            end
        end else begin
            cycle++;
            // results leave before this edge's window is queued
            if (out_valid) begin
                got = '{res0, res1, res2, res3};
                if (exp_q.size() < 4) begin
                    $display("out_valid went high with no expected result queued");
                    other_errors++;
                end else begin
                    compared++;
                    lat = cycle - cap_q.pop_front();
                    if (lat != LATENCY) begin
                        $display("result came %0d cycles after its window, expected %0d",
                                 lat, LATENCY);
                        other_errors++;
                    end
                    for (int i = 0; i < 4; i++) begin
                        want = exp_q.pop_front();
                        if (got[i] !== want) begin
                            $display("Error: res%0d = 0x%h, expected 0x%h", i, got[i], want);
                            value_errors++;
                        end
                    end
                end
            end
            if (window_valid) begin
                cap_q.push_back(cycle);
                for (int k = 0; k < 4; k++) begin
                    exp_q.push_back(expected_pixel({win0, win1, win2, win3}, k, layer));
                end
            end
            if (weight_load) begin
                for (int c = 0; c < `CH_NUM - 1; c++) begin
                    kern[c] = kern[c+1];
                end
                for (int p = 0; p < `WEIGHT_PER_ADDR; p++) begin
                    kern[`CH_NUM-1][p] = weight_word[`WEIGHT_WORD_W-1-4*p -: 4];
                end
            end
            if (bias_load) begin
                bias_m = bias;
            end
        end
        pending <= exp_q.size();
    end

endmodule

`default_nettype wire

// File: tb/tb_conv_pe.sv
`default_nettype none

`include "conv_pe_defines.svh"

module tb_conv_pe;

    localparam int CLK_PERIOD  = 40;
    localparam int N_BURSTS    = 12;
    localparam int BURST_LEN   = 10;
    localparam int DRAIN_MAX   = 8;
    localparam int N_ONEHOT    = `CH_NUM * `WEIGHT_PER_ADDR;
    localparam int NUM_PHASES  = 4 + N_ONEHOT + N_BURSTS;
    localparam int NUM_LOADS   = NUM_PHASES * (`CH_NUM + 1);
    localparam int NUM_WINDOWS = 18 + N_ONEHOT + N_BURSTS * BURST_LEN;
    localparam int TIMEOUT     =
        (NUM_WINDOWS + NUM_LOADS + NUM_PHASES * DRAIN_MAX + 50) * CLK_PERIOD;

    logic                         clk;
    logic                         rst_n;
    logic                         window_valid;
    logic                         layer;
    logic [`ACT_WORD_W-1:0]       win0;
    logic [`ACT_WORD_W-1:0]       win1;
    logic [`ACT_WORD_W-1:0]       win2;
    logic [`ACT_WORD_W-1:0]       win3;
    logic                         weight_load;
    logic [`WEIGHT_WORD_W-1:0]    weight_word;
    logic                         bias_load;
    logic [`BW_PER_PARAM-1:0]     bias;
    logic                         out_valid;
    logic [`BW_PER_ACT-1:0]       res0;
    logic [`BW_PER_ACT-1:0]       res1;
    logic [`BW_PER_ACT-1:0]       res2;
    logic [`BW_PER_ACT-1:0]       res3;
    int                           value_errors;
    int                           other_errors;
    int                           compared;
    int                           pending;

    conv_pe_top i_conv_pe_top (.*);

    conv_pe_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout, the DUT stopped producing results");
        $display("test failed");
        $finish;
    end

    function automatic logic [`ACT_WORD_W-1:0] rand_act_word();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    function automatic logic [`WEIGHT_WORD_W-1:0] rand_kernel();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[`WEIGHT_WORD_W-1:0];
    endfunction

    task automatic idle();
        @(posedge clk);
        window_valid <= 1'b0;
        weight_load  <= 1'b0;
        bias_load    <= 1'b0;
    endtask

    // four kernels in channel order and then the bias
    task automatic load_params(
        input logic [`WEIGHT_WORD_W-1:0] k0, k1, k2, k3,
        input logic [`BW_PER_PARAM-1:0]  b
    );
        logic [`WEIGHT_WORD_W-1:0] kset [4];
        kset = '{k0, k1, k2, k3};
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            window_valid <= 1'b0;
            bias_load    <= 1'b0;
            weight_load  <= 1'b1;
            weight_word  <= kset[c];
        end
        @(posedge clk);
        weight_load <= 1'b0;
        bias_load   <= 1'b1;
        bias        <= b;
    endtask

    task automatic send_window(input logic [`ACT_WORD_W-1:0] w0, w1, w2, w3, input logic lay);
        @(posedge clk);
        weight_load  <= 1'b0;
        bias_load    <= 1'b0;
        window_valid <= 1'b1;
        layer        <= lay;
        win0         <= w0;
        win1         <= w1;
        win2         <= w2;
        win3         <= w3;
    endtask

    task automatic send_random(input logic lay);
        send_window(rand_act_word(), rand_act_word(), rand_act_word(), rand_act_word(), lay);
    endtask

    task automatic send_fill(input logic [`BW_PER_ACT-1:0] v, input logic lay);
        send_window({16{v}}, {16{v}}, {16{v}}, {16{v}}, lay);
    endtask

    // let every queued result come out before the next load
    task automatic drain();
        idle();
        idle();
        for (int i = 0; i < DRAIN_MAX && pending != 0; i++) begin
            idle();
        end
    endtask

    initial begin
        logic [`WEIGHT_WORD_W-1:0] hot [4];
        int extra;
        extra        = 0;
        rst_n        = 1'b0;
        window_valid = 1'b0;
        layer        = 1'b0;
        win0         = '0;
        win1         = '0;
        win2         = '0;
        win3         = '0;
        weight_load  = 1'b0;
        weight_word  = '0;
        bias_load    = 1'b0;
        bias         = '0;
        void'($urandom(67));
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // zero kernels leave only the bias
        load_params('0, '0, '0, '0, 4'd5);
        for (int i = 0; i < 6; i++) begin
            send_random(i >= 3);
        end
        drain();

        // single unit weight walks every channel and position
        for (int ch = 0; ch < `CH_NUM; ch++) begin
            for (int p = 0; p < `WEIGHT_PER_ADDR; p++) begin
                for (int c = 0; c < 4; c++) begin
                    hot[c] = (c == ch) ? (36'h1 << (4 * (8 - p))) : '0;
                end
                load_params(hot[0], hot[1], hot[2], hot[3], 4'd0);
                send_random(1'b1);
                drain();
            end
        end

        // saturation at the top and then negative sums
        load_params(36'h777777777, 36'h777777777, 36'h777777777, 36'h777777777, 4'd7);
        send_fill(8'h40, 1'b0);
        send_fill(8'h40, 1'b1);
        drain();
        load_params(36'h888888888, 36'h888888888, 36'h888888888, 36'h888888888, 4'h8);
        send_fill(8'h40, 1'b0);
        send_fill(8'h40, 1'b1);
        drain();

        // back-to-back windows with alternating modes
        load_params(rand_kernel(), rand_kernel(), rand_kernel(), rand_kernel(), 4'($urandom()));
        for (int i = 0; i < 8; i++) begin
            send_random(i % 2 == 1);
        end
        drain();

        for (int n = 0; n < N_BURSTS; n++) begin
            load_params(rand_kernel(), rand_kernel(), rand_kernel(), rand_kernel(),
                        4'($urandom()));
            for (int i = 0; i < BURST_LEN; i++) begin
                send_random($urandom() % 2 == 1);
            end
            drain();
        end

        if (pending != 0) begin
            $display("%0d expected results were never produced", pending);
            extra++;
        end
        if (compared != NUM_WINDOWS) begin
            $display("only %0d of %0d windows were checked", compared, NUM_WINDOWS);
            extra++;
        end
        $display("windows checked %0d, value errors %0d, other errors %0d",
                 compared, value_errors, other_errors + extra);
        if (value_errors == 0 && other_errors + extra == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/conv_pe_pkg.sv
source/acc_if.sv
source/param_buffer.sv
source/conv_mac.sv
source/requant_relu.sv
source/conv_pe_top.sv
tb/conv_pe_checker.sv
tb/tb_conv_pe.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_conv_pe
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
